// File: flist.f
+incdir+include
logic/hl2_cmd_pkg.sv
logic/hl2_state_pkg.sv
logic/cmd_if.sv
logic/cmd_sync.sv
logic/cmd_regs.sv
logic/tr_sequencer.sv
logic/status_leds.sv
logic/hl2_ctrl_top.sv
tests/hl2_ctrl_checker.sv
tests/hl2_ctrl_tb.sv

// File: include/hl2_macros.svh
/*
 * HL2 control core constants
 * widths, register map and timing counts for the clk_ctrl domain
 */
`ifndef HL2_MACROS_SVH
`define HL2_MACROS_SVH

////////////////////////////////////////
// command and response widths
////////////////////////////////////////
`define HL2_ADDR_W 6
`define HL2_DATA_W 32
`define HL2_RESP_W 40
`define HL2_HANG_W 8

////////////////////////////////////////
// register map
////////////////////////////////////////
`define HL2_ADDR_PA_CFG 6'h09
`define HL2_ADDR_HANG 6'h17

// pa config bit positions
`define HL2_PA_CFG_W 3
`define HL2_PA_EN_BIT 0
`define HL2_EXT_EN_BIT 1
`define HL2_RFSW_BIT 2

////////////////////////////////////////
// timing in clk_ctrl cycles
////////////////////////////////////////
// relay settle before internal t/r
`define HL2_TR_SETTLE 8
`define HL2_HANG_STEP 16
`define HL2_CLIP_HOLD 64

`endif

// File: logic/cmd_if.sv
/*
 * Command bus
 * one synchronized command with a single cycle request strobe
 */
`timescale 1ns/1ns

interface cmd_if;

	hl2_cmd_pkg::cmd_addr_t addr;
	hl2_cmd_pkg::cmd_data_t data;
	// sender wants a response word back
	logic resprqst;
	// one cycle per command, fields stable while high
	logic rqst;

	modport sender (
		output addr,
		output data,
		output resprqst,
		output rqst
	);

	modport receiver (
		input addr,
		input data,
		input resprqst,
		input rqst
	);

endinterface

// File: logic/cmd_regs.sv
/*
 * Command register file
 * pa configuration and t/r hang registers plus the 40 bit response
 */
`timescale 1ns/1ns
`include "hl2_macros.svh"

module cmd_regs (
	input logic clk_ctrl,
	input logic rst_n_i,
	cmd_if.receiver cmd_i,
	input logic tx_active_i,
	output logic pa_en_o,
	output logic ext_en_o,
	output logic rfsw_sel_o,
	output hl2_cmd_pkg::hang_cnt_t hang_o,
	output hl2_cmd_pkg::resp_word_t resp_o,
	output logic resp_valid_o
);

	logic [`HL2_PA_CFG_W-1:0] pa_cfg_q;
	logic [`HL2_PA_CFG_W-1:0] pa_cfg_d;
	hl2_cmd_pkg::hang_cnt_t hang_q;
	hl2_cmd_pkg::hang_cnt_t hang_d;
	logic addr_known;
	hl2_cmd_pkg::cmd_data_t rd_data;

	////////////////////////////////////////
	// address decode
	////////////////////////////////////////
	// next contents and readback after the write
	always_comb
	begin
		pa_cfg_d = pa_cfg_q;
		hang_d = hang_q;
		addr_known = 1'b0;
		rd_data = '0;
		case (cmd_i.addr)
			`HL2_ADDR_PA_CFG:
			begin
				addr_known = 1'b1;
				pa_cfg_d = cmd_i.data[`HL2_PA_CFG_W-1:0];
				rd_data = hl2_cmd_pkg::cmd_data_t'(pa_cfg_d);
			end
			`HL2_ADDR_HANG:
			begin
				addr_known = 1'b1;
				hang_d = cmd_i.data[`HL2_HANG_W-1:0];
				rd_data = hl2_cmd_pkg::cmd_data_t'(hang_d);
			end
			default:
			begin
				// unknown address reads back as zero
				rd_data = '0;
			end
		endcase
	end

	////////////////////////////////////////
	// registers
	////////////////////////////////////////
	always_ff @(posedge clk_ctrl)
	begin
		if (!rst_n_i)
		begin
			pa_cfg_q <= '0;
			hang_q <= '0;
		end
		else if (cmd_i.rqst)
		begin
			pa_cfg_q <= pa_cfg_d;
			hang_q <= hang_d;
		end
	end

	// response word one cycle after the request
	always_ff @(posedge clk_ctrl)
	begin
		if (!rst_n_i)
		begin
			resp_o <= '0;
			resp_valid_o <= 1'b0;
		end
		else
		begin
			resp_valid_o <= cmd_i.rqst & cmd_i.resprqst;
			if (cmd_i.rqst && cmd_i.resprqst)
			begin
				resp_o <= {cmd_i.addr, tx_active_i, addr_known, rd_data};
			end
		end
	end

	assign pa_en_o = pa_cfg_q[`HL2_PA_EN_BIT];
	assign ext_en_o = pa_cfg_q[`HL2_EXT_EN_BIT];
	assign rfsw_sel_o = pa_cfg_q[`HL2_RFSW_BIT];
	assign hang_o = hang_q;

endmodule

// File: logic/cmd_sync.sv
/*
 * Command receiver
 * brings the command toggle into clk_ctrl, latches the fields
 * and raises a one cycle request
 */
`timescale 1ns/1ns

module cmd_sync (
	input logic clk_ctrl,
	input logic rst_n_i,
	input logic cmd_cnt_i,
	input hl2_cmd_pkg::cmd_addr_t cmd_addr_i,
	input hl2_cmd_pkg::cmd_data_t cmd_data_i,
	input logic cmd_resprqst_i,
	cmd_if.sender cmd_o
);

	logic [1:0] cnt_sync_q;
	logic cnt_seen_q;
	logic cnt_change;
	logic hit_q;
	logic rqst_q;

	////////////////////////////////////////
	// toggle synchronizer
	////////////////////////////////////////
	always_ff @(posedge clk_ctrl)
	begin
		if (!rst_n_i)
		begin
			cnt_sync_q <= 2'b00;
			cnt_seen_q <= 1'b0;
			hit_q <= 1'b0;
			rqst_q <= 1'b0;
		end
		else
		begin
			cnt_sync_q <= {cnt_sync_q[0], cmd_cnt_i};
			cnt_seen_q <= cnt_sync_q[1];
			hit_q <= cnt_change;
			rqst_q <= hit_q;
		end
	end

	// any edge of the count marks a new command
	assign cnt_change = cnt_sync_q[1] ^ cnt_seen_q;

	////////////////////////////////////////
	// field capture
	////////////////////////////////////////
	// sender holds the fields well past this point
	always_ff @(posedge clk_ctrl)
	begin
		if (hit_q)
		begin
			cmd_o.addr <= cmd_addr_i;
			cmd_o.data <= cmd_data_i;
			cmd_o.resprqst <= cmd_resprqst_i;
		end
	end

	assign cmd_o.rqst = rqst_q;

endmodule

// File: logic/hl2_cmd_pkg.sv
/*
 * HL2 command types
 * vectors for the command bus, the response word and the hang count
 */
`include "hl2_macros.svh"

package hl2_cmd_pkg;

	// command bus fields
	typedef logic [`HL2_ADDR_W-1:0] cmd_addr_t;
	typedef logic [`HL2_DATA_W-1:0] cmd_data_t;

	// {addr, tx active, known, data}
	typedef logic [`HL2_RESP_W-1:0] resp_word_t;

	// t/r hang time in steps of HL2_HANG_STEP
	typedef logic [`HL2_HANG_W-1:0] hang_cnt_t;

endpackage

// File: logic/hl2_ctrl_top.sv
/*
 * HL2 control core
 * command reception, register file, t/r sequencing and status leds
 */
`timescale 1ns/1ns

module hl2_ctrl_top (
	input logic clk_ctrl,
	input logic rst_n_i,
	input logic cmd_cnt_i,
	input hl2_cmd_pkg::cmd_addr_t cmd_addr_i,
	input hl2_cmd_pkg::cmd_data_t cmd_data_i,
	input logic cmd_resprqst_i,
	input logic tx_req_i,
	input logic io_tx_inhibit_i,
	input logic run_i,
	input logic rxclip_i,
	output logic pa_inttr_o,
	output logic pa_exttr_o,
	output logic rfsw_sel_o,
	output logic led_run_o,
	output logic led_tx_o,
	output logic led_clip_o,
	output hl2_cmd_pkg::resp_word_t resp_o,
	output logic resp_valid_o
);

	logic pa_en;
	logic ext_en;
	hl2_cmd_pkg::hang_cnt_t hang;
	logic tx_active;

	// synchronized command
	cmd_if u_cmd_if ();

	cmd_sync u_cmd_sync (
		.clk_ctrl       (clk_ctrl),
		.rst_n_i        (rst_n_i),
		.cmd_cnt_i      (cmd_cnt_i),
		.cmd_addr_i     (cmd_addr_i),
		.cmd_data_i     (cmd_data_i),
		.cmd_resprqst_i (cmd_resprqst_i),
		.cmd_o          (u_cmd_if.sender)
	);

	cmd_regs u_cmd_regs (
		.clk_ctrl     (clk_ctrl),
		.rst_n_i      (rst_n_i),
		.cmd_i        (u_cmd_if.receiver),
		.tx_active_i  (tx_active),
		.pa_en_o      (pa_en),
		.ext_en_o     (ext_en),
		.rfsw_sel_o   (rfsw_sel_o),
		.hang_o       (hang),
		.resp_o       (resp_o),
		.resp_valid_o (resp_valid_o)
	);

	tr_sequencer u_tr_sequencer (
		.clk_ctrl    (clk_ctrl),
		.rst_n_i     (rst_n_i),
		.tx_req_i    (tx_req_i),
		.inhibit_i   (io_tx_inhibit_i),
		.pa_en_i     (pa_en),
		.ext_en_i    (ext_en),
		.hang_i      (hang),
		.pa_inttr_o  (pa_inttr_o),
		.pa_exttr_o  (pa_exttr_o),
		.tx_active_o (tx_active)
	);

	status_leds u_status_leds (
		.clk_ctrl    (clk_ctrl),
		.rst_n_i     (rst_n_i),
		.run_i       (run_i),
		.tx_active_i (tx_active),
		.rxclip_i    (rxclip_i),
		.led_run_o   (led_run_o),
		.led_tx_o    (led_tx_o),
		.led_clip_o  (led_clip_o)
	);

endmodule

// File: logic/hl2_state_pkg.sv
/*
 * HL2 state machine encodings
 */
package hl2_state_pkg;

	// t/r relay sequencing
	typedef enum logic [1:0] {
		TR_RX    = 2'd0,
		TR_KEYUP = 2'd1,
		TR_TX    = 2'd2,
		TR_HANG  = 2'd3
	} tr_state_t;

endpackage

// File: logic/status_leds.sv
/*
 * Status LEDs
 * run and transmit indicators plus a stretched adc clip light
 */
`timescale 1ns/1ns
`include "hl2_macros.svh"

module status_leds (
	input logic clk_ctrl,
	input logic rst_n_i,
	input logic run_i,
	input logic tx_active_i,
	input logic rxclip_i,
	output logic led_run_o,
	output logic led_tx_o,
	output logic led_clip_o
);

	localparam int HOLD_W = $clog2(`HL2_CLIP_HOLD + 1);

	logic [HOLD_W-1:0] clip_cnt_q;

	always_ff @(posedge clk_ctrl)
	begin
		if (!rst_n_i)
		begin
			led_run_o <= 1'b0;
			led_tx_o <= 1'b0;
			led_clip_o <= 1'b0;
			clip_cnt_q <= '0;
		end
		else
		begin
			led_run_o <= run_i;
			led_tx_o <= tx_active_i;
			// each clip restarts the hold time
			if (rxclip_i)
				clip_cnt_q <= HOLD_W'(`HL2_CLIP_HOLD);
			else if (clip_cnt_q != '0)
				clip_cnt_q <= clip_cnt_q - 1'b1;
			led_clip_o <= rxclip_i | (clip_cnt_q != '0);
		end
	end

endmodule

// File: logic/tr_sequencer.sv
/*
 * T/R sequencer
 * keys the external relay first, then internal t/r after settling,
 * holds the relay through the hang time; inhibit forces receive
 */
`timescale 1ns/1ns
`include "hl2_macros.svh"

module tr_sequencer (
	input logic clk_ctrl,
	input logic rst_n_i,
	input logic tx_req_i,
	input logic inhibit_i,
	input logic pa_en_i,
	input logic ext_en_i,
	input hl2_cmd_pkg::hang_cnt_t hang_i,
	output logic pa_inttr_o,
	output logic pa_exttr_o,
	output logic tx_active_o
);

	// wide enough for the longest hang time
	localparam int CNT_W = $clog2((2 ** `HL2_HANG_W) * `HL2_HANG_STEP);

	hl2_state_pkg::tr_state_t state_q;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] hang_load;
	logic req_q;
	logic req_rise;
	logic tx_on;

	assign req_rise = tx_req_i & ~req_q;

	// zero hang still spends one cycle in TR_HANG
	assign hang_load = (hang_i == '0) ? '0 : CNT_W'(hang_i * `HL2_HANG_STEP - 1);

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////
	always_ff @(posedge clk_ctrl)
	begin
		if (!rst_n_i)
		begin
			state_q <= hl2_state_pkg::TR_RX;
			cnt_q <= '0;
			req_q <= 1'b0;
		end
		else
		begin
			req_q <= tx_req_i;
			if (inhibit_i)
			begin
				state_q <= hl2_state_pkg::TR_RX;
				cnt_q <= '0;
			end
			else
			begin
				case (state_q)
					hl2_state_pkg::TR_RX:
					begin
						if (req_rise)
						begin
							state_q <= hl2_state_pkg::TR_KEYUP;
							cnt_q <= CNT_W'(`HL2_TR_SETTLE - 1);
						end
					end
					hl2_state_pkg::TR_KEYUP:
					begin
						if (!tx_req_i)
						begin
							state_q <= hl2_state_pkg::TR_HANG;
							cnt_q <= hang_load;
						end
						else if (cnt_q == '0)
							state_q <= hl2_state_pkg::TR_TX;
						else
							cnt_q <= cnt_q - 1'b1;
					end
					hl2_state_pkg::TR_TX:
					begin
						if (!tx_req_i)
						begin
							state_q <= hl2_state_pkg::TR_HANG;
							cnt_q <= hang_load;
						end
					end
					default:
					begin
						// TR_HANG
						if (cnt_q == '0)
							state_q <= hl2_state_pkg::TR_RX;
						else
							cnt_q <= cnt_q - 1'b1;
					end
				endcase
			end
		end
	end

	////////////////////////////////////////
	// outputs
	////////////////////////////////////////
	assign tx_on = (state_q == hl2_state_pkg::TR_TX);
	assign tx_active_o = tx_on;
	assign pa_inttr_o = tx_on & pa_en_i;
	// relay stays keyed until the sequence is back in receive
	assign pa_exttr_o = (state_q != hl2_state_pkg::TR_RX) & ext_en_i;

endmodule

// File: run.sh
#!/bin/sh
# build the control core testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ns -Wno-fatal --top-module hl2_ctrl_tb \
	-f flist.f -o hl2_ctrl_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/hl2_ctrl_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tests/hl2_ctrl_checker.sv
/*
 * HL2 control core checker
 * t/r safety and response strobe assertions for the top level
 */
`timescale 1ns/1ns

module hl2_ctrl_checker (
	input logic clk_ctrl,
	input logic rst_n_i,
	input logic inhibit_i,
	input logic ext_en_i,
	input logic pa_inttr_i,
	input logic pa_exttr_i,
	input logic resp_valid_i
);

	// failed assertion count
	int fail_cnt = 0;

	// inhibit forces receive at the next edge
	inhibit_drops_inttr: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
		inhibit_i |=> !pa_inttr_i)
	else
	begin
		$error("internal t/r still high the cycle after tx inhibit");
		fail_cnt++;
	end

	resp_single_pulse: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
		resp_valid_i |=> !resp_valid_i)
	else
	begin
		$error("response strobe high for two cycles in a row");
		fail_cnt++;
	end

	// internal t/r only once the relay has been keyed
	inttr_needs_exttr: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
		(ext_en_i && $past(ext_en_i) && pa_inttr_i) |-> (pa_exttr_i && $past(pa_exttr_i)))
	else
	begin
		$error("internal t/r high without the relay keyed the cycle before");
		fail_cnt++;
	end

endmodule

bind hl2_ctrl_top hl2_ctrl_checker u_checker (
	.clk_ctrl     (clk_ctrl),
	.rst_n_i      (rst_n_i),
	.inhibit_i    (io_tx_inhibit_i),
	.ext_en_i     (ext_en),
	.pa_inttr_i   (pa_inttr_o),
	.pa_exttr_i   (pa_exttr_o),
	.resp_valid_i (resp_valid_o)
);

// File: tests/hl2_ctrl_tb.sv
/*
 * HL2 control core testbench
 * command table, t/r sequence and led checks on hl2_ctrl_top
 */
`timescale 1ns/1ns
`include "hl2_macros.svh"

module hl2_ctrl_tb;

	localparam int NROWS = 7;
	localparam int RESP_LIMIT = 16;
	localparam int CMD_GAP = 8;
	localparam int HANG_SET = 2;
	localparam int P_EXTTR = 0;
	localparam int P_INTTR = 1;
	localparam int P_LED_TX = 2;
	localparam int P_LED_RUN = 3;
	localparam int P_LED_CLIP = 4;

	typedef struct packed {
		hl2_cmd_pkg::cmd_addr_t addr;
		hl2_cmd_pkg::cmd_data_t data;
		logic resp_rq;
		logic tx_req;
		logic inhibit;
		logic exp_rfsw;
		logic exp_exttr;
		logic exp_inttr;
		hl2_cmd_pkg::resp_word_t exp_resp;
	} stim_row_t;

	logic clk_ctrl;
	logic rst_n_i;
	logic cmd_cnt_i;
	hl2_cmd_pkg::cmd_addr_t cmd_addr_i;
	hl2_cmd_pkg::cmd_data_t cmd_data_i;
	logic cmd_resprqst_i;
	logic tx_req_i;
	logic io_tx_inhibit_i;
	logic run_i;
	logic rxclip_i;
	logic pa_inttr_o;
	logic pa_exttr_o;
	logic rfsw_sel_o;
	logic led_run_o;
	logic led_tx_o;
	logic led_clip_o;
	hl2_cmd_pkg::resp_word_t resp_o;
	logic resp_valid_o;

	stim_row_t rows [NROWS];
	int checks;
	int errors;
	int timeouts;

	hl2_ctrl_top u_dut (.*);

	always #50 clk_ctrl = ~clk_ctrl;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	// random upper bits, fixed low field
	function automatic hl2_cmd_pkg::cmd_data_t with_low(input int width,
		input hl2_cmd_pkg::cmd_data_t low);
		hl2_cmd_pkg::cmd_data_t mask;
		hl2_cmd_pkg::cmd_data_t rnd;
		mask = (32'h1 << width) - 1;
		rnd = $urandom;
		return (rnd & ~mask) | (low & mask);
	endfunction

	// {addr, tx active, known, data}
	function automatic hl2_cmd_pkg::resp_word_t resp_word(input hl2_cmd_pkg::cmd_addr_t addr,
		input logic tx, input logic known, input hl2_cmd_pkg::cmd_data_t data);
		return {addr, tx, known, data};
	endfunction

	function automatic logic probe(input int sel);
		case (sel)
			P_EXTTR: return pa_exttr_o;
			P_INTTR: return pa_inttr_o;
			P_LED_TX: return led_tx_o;
			P_LED_RUN: return led_run_o;
			default: return led_clip_o;
		endcase
	endfunction

	task automatic check_word(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int n, input int lo, input int hi);
		checks++;
		if (n < lo || n > hi)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s took %0d cycles, expected %0d to %0d",
				$time, what, n, lo, hi);
		end
	endtask

	// polls at the falling edge until the output reaches the level
	task automatic wait_for(input int sel, input logic level, input int limit,
		input string what, output int cycles);
		cycles = 0;
		do
		begin
			@(negedge clk_ctrl);
			cycles++;
		end
		while (probe(sel) !== level && cycles < limit);
		if (probe(sel) !== level)
		begin
			timeouts++;
			$display("timeout: %s did not reach %0b within %0d cycles", what, level, limit);
		end
	endtask

	task automatic send_cmd(input stim_row_t r);
		@(posedge clk_ctrl);
		cmd_addr_i <= r.addr;
		cmd_data_i <= r.data;
		cmd_resprqst_i <= r.resp_rq;
		cmd_cnt_i <= ~cmd_cnt_i;
	endtask

	task automatic wait_resp(input int row, output logic seen);
		int n;
		n = 0;
		do
		begin
			@(negedge clk_ctrl);
			n++;
		end
		while (resp_valid_o !== 1'b1 && n < RESP_LIMIT);
		seen = (resp_valid_o === 1'b1);
		if (!seen)
		begin
			timeouts++;
			$display("timeout: no response strobe for row %0d within %0d cycles", row, n);
		end
	endtask

	task automatic expect_quiet(input int row);
		repeat (CMD_GAP)
		begin
			@(negedge clk_ctrl);
			if (resp_valid_o !== 1'b0)
			begin
				errors++;
				$display("[ERROR] %0t ns: row %0d gave an unrequested response", $time, row);
			end
		end
	endtask

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////
	// addr, data, resp, tx, inhibit, rfsw, exttr, inttr, response
	task automatic fill_table();
		rows[0] = '{`HL2_ADDR_PA_CFG, with_low(3, 32'h7), 1'b1, 1'b0, 1'b0,
			1'b1, 1'b0, 1'b0, resp_word(`HL2_ADDR_PA_CFG, 1'b0, 1'b1, 32'h7)};
		rows[1] = '{`HL2_ADDR_HANG, with_low(8, HANG_SET), 1'b1, 1'b0, 1'b0,
			1'b1, 1'b0, 1'b0, resp_word(`HL2_ADDR_HANG, 1'b0, 1'b1, HANG_SET)};
		// unknown address leaves the outputs alone
		rows[2] = '{6'h3a, $urandom, 1'b1, 1'b0, 1'b0,
			1'b1, 1'b0, 1'b0, resp_word(6'h3a, 1'b0, 1'b0, 32'h0)};
		rows[3] = '{`HL2_ADDR_PA_CFG, with_low(3, 32'h7), 1'b1, 1'b1, 1'b0,
			1'b1, 1'b1, 1'b1, resp_word(`HL2_ADDR_PA_CFG, 1'b1, 1'b1, 32'h7)};
		// inhibit during transmit
		rows[4] = '{`HL2_ADDR_HANG, with_low(8, HANG_SET), 1'b1, 1'b1, 1'b1,
			1'b1, 1'b0, 1'b0, resp_word(`HL2_ADDR_HANG, 1'b0, 1'b1, HANG_SET)};
		rows[5] = '{6'h00, $urandom, 1'b0, 1'b0, 1'b0,
			1'b1, 1'b0, 1'b0, '0};
		rows[6] = '{`HL2_ADDR_PA_CFG, with_low(3, 32'h3), 1'b1, 1'b0, 1'b0,
			1'b0, 1'b0, 1'b0, resp_word(`HL2_ADDR_PA_CFG, 1'b0, 1'b1, 32'h3)};
	endtask

	task automatic run_row(input int i);
		logic seen;
		int n;
		@(posedge clk_ctrl);
		tx_req_i <= rows[i].tx_req;
		io_tx_inhibit_i <= rows[i].inhibit;
		wait_for(P_EXTTR, rows[i].exp_exttr, 4 * `HL2_TR_SETTLE, "pa_exttr_o", n);
		wait_for(P_INTTR, rows[i].exp_inttr, 4 * `HL2_TR_SETTLE, "pa_inttr_o", n);
		send_cmd(rows[i]);
		if (rows[i].resp_rq)
		begin
			wait_resp(i, seen);
			if (seen)
				check_word($sformatf("row %0d resp_o", i), resp_o, rows[i].exp_resp);
		end
		else
			expect_quiet(i);
		check_word($sformatf("row %0d rfsw_sel_o", i), rfsw_sel_o, rows[i].exp_rfsw);
		check_word($sformatf("row %0d pa_exttr_o", i), pa_exttr_o, rows[i].exp_exttr);
		check_word($sformatf("row %0d pa_inttr_o", i), pa_inttr_o, rows[i].exp_inttr);
		// command spacing
		repeat (CMD_GAP) @(posedge clk_ctrl);
	endtask

	////////////////////////////////////////
	// t/r sequence and leds
	////////////////////////////////////////
	task automatic run_tr_sequence();
		int n;
		@(posedge clk_ctrl);
		tx_req_i <= 1'b1;
		wait_for(P_EXTTR, 1'b1, 8, "pa_exttr_o on key up", n);
		check_word("pa_inttr_o while the relay settles", pa_inttr_o, 1'b0);
		wait_for(P_INTTR, 1'b1, 4 * `HL2_TR_SETTLE, "pa_inttr_o after settling", n);
		check_count("relay settle", n, `HL2_TR_SETTLE, 4 * `HL2_TR_SETTLE);
		wait_for(P_LED_TX, 1'b1, 4, "led_tx_o", n);
		@(posedge clk_ctrl);
		tx_req_i <= 1'b0;
		wait_for(P_INTTR, 1'b0, 4, "pa_inttr_o release", n);
		check_word("pa_exttr_o at start of hang", pa_exttr_o, 1'b1);
		wait_for(P_EXTTR, 1'b0, HANG_SET * `HL2_HANG_STEP + 16, "pa_exttr_o after hang", n);
		check_count("hang time", n, HANG_SET * `HL2_HANG_STEP,
			HANG_SET * `HL2_HANG_STEP + 16);
		check_word("led_tx_o after hang", led_tx_o, 1'b0);
	endtask

	task automatic run_led_test();
		int n;
		@(posedge clk_ctrl);
		run_i <= 1'b1;
		wait_for(P_LED_RUN, 1'b1, 4, "led_run_o", n);
		@(posedge clk_ctrl);
		rxclip_i <= 1'b1;
		@(posedge clk_ctrl);
		rxclip_i <= 1'b0;
		wait_for(P_LED_CLIP, 1'b1, 4, "led_clip_o on a clip", n);
		wait_for(P_LED_CLIP, 1'b0, `HL2_CLIP_HOLD + 8, "led_clip_o going dark", n);
		check_count("clip hold", n, `HL2_CLIP_HOLD, `HL2_CLIP_HOLD + 8);
		check_word("led_run_o while running", led_run_o, 1'b1);
	endtask

	initial
	begin
		clk_ctrl = 1'b0;
		rst_n_i = 1'b0;
		cmd_cnt_i = 1'b0;
		cmd_addr_i = '0;
		cmd_data_i = '0;
		cmd_resprqst_i = 1'b0;
		tx_req_i = 1'b0;
		io_tx_inhibit_i = 1'b0;
		run_i = 1'b0;
		rxclip_i = 1'b0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		void'($urandom(24));
		fill_table();

		repeat (3) @(posedge clk_ctrl);
		rst_n_i <= 1'b1;
		@(negedge clk_ctrl);
		check_word("outputs after reset", {pa_inttr_o, pa_exttr_o, rfsw_sel_o, led_run_o,
			led_tx_o, led_clip_o, resp_valid_o}, '0);
		check_word("resp_o after reset", resp_o, '0);

		for (int i = 0; i < NROWS; i++)
			run_row(i);
		run_tr_sequence();
		run_led_test();

		$display("checks: %0d, value errors: %0d, timeouts: %0d, assertion failures: %0d",
			checks, errors, timeouts, u_dut.u_checker.fail_cnt);
		if (errors == 0 && timeouts == 0 && u_dut.u_checker.fail_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
